// File: fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// instruction address width
`define FETCH_ADDR_W 32
// pc loaded on a reset request
`define FETCH_RST_PC 32'h0000_0000
// entries in the fetch result buffer
`define IF_RES_DEPTH 3
// requests issued and not yet taken by decode
`define IMEM_MAX_OUTSTANDING 3

`endif

// File: fetch_bus_pkg.sv
`default_nettype none

`include "fetch_defines.svh"

package fetch_bus_pkg;

	typedef logic [`FETCH_ADDR_W-1:0] addr_t; // fetch address
	typedef logic [31:0] inst_t; // raw instruction word

	// error code returned with each memory response
	typedef enum logic [1:0] {
		IMEM_OK        = 2'b00,
		IMEM_MISALIGN  = 2'b01, // pc not word aligned
		IMEM_BUS_ERR   = 2'b10,
		IMEM_TIMEOUT   = 2'b11
	} imem_err_e;

	typedef logic [1:0] outstanding_t; // 0..3 requests in flight

endpackage

`default_nettype wire

// File: fetch_inst_pkg.sv
`default_nettype none

package fetch_inst_pkg;

	// rv32i major opcodes
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_IMM    = 7'b0010011,
		OPC_REG    = 7'b0110011,
		OPC_FENCE  = 7'b0001111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	// pre-decode info, 64 bits
	typedef struct packed {
		logic [18:0] rsvd; // always zero
		logic        is_branch;
		logic        is_jal;
		logic        is_jalr;
		logic [4:0]  rs1;
		logic [4:0]  rd;
		logic [31:0] imm; // sign extended, format per type
	} predec_msg_t;

	// side info stored with each fetched word
	typedef struct packed {
		logic                     jump; // predicted taken
		logic                     illegal;
		fetch_bus_pkg::imem_err_e err;
	} if_res_msg_t;

endpackage

`default_nettype wire

// File: fetch_ifs.sv
`default_nettype none

// current word to the pre-decoder and next pc back to the controller
interface predec_if;

	fetch_bus_pkg::inst_t         now_inst;
	fetch_bus_pkg::addr_t         now_pc;
	fetch_inst_pkg::predec_msg_t  msg;
	logic                         is_jalr;
	logic                         illegal; // bad low bits or unknown opcode
	fetch_bus_pkg::addr_t         new_pc;
	logic                         to_jump;

	modport ctrl (output now_inst, now_pc, input msg, is_jalr, illegal, new_pc, to_jump);
	modport dec (input now_inst, output msg, is_jalr, illegal);
	modport pcgen (input now_pc, msg, output new_pc, to_jump);

endinterface

// write side of the result buffer
interface if_res_wr_if;

	logic                         wen;
	logic                         clr; // reset or flush pulse
	fetch_bus_pkg::addr_t         pc;
	fetch_bus_pkg::inst_t         inst;
	fetch_inst_pkg::predec_msg_t  predec;
	fetch_inst_pkg::if_res_msg_t  msg;
	logic                         full;

	modport wr (output wen, clr, pc, inst, predec, msg, input full);
	// buffer side
	modport fifo (input wen, clr, pc, inst, predec, msg, output full);

endinterface

`default_nettype wire

// File: inst_predecoder.sv
`default_nettype none

module inst_predecoder (
	predec_if.dec p
);

	fetch_bus_pkg::inst_t    inst;
	fetch_inst_pkg::opcode_e opc;
	logic                    known; // opcode is one of the rv32i majors

	assign inst = p.now_inst;
	assign opc = fetch_inst_pkg::opcode_e'(inst[6:0]);

	always_comb
	begin
		p.msg = '0;
		known = 1'b1;
		p.msg.rs1 = inst[19:15];
		p.msg.rd = inst[11:7];
		case (opc)
			fetch_inst_pkg::OPC_JAL:
			begin
				p.msg.is_jal = 1'b1;
				p.msg.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0}; // j-type
			end
			fetch_inst_pkg::OPC_JALR:
			begin
				p.msg.is_jalr = 1'b1;
				p.msg.imm = {{20{inst[31]}}, inst[31:20]};
			end
			fetch_inst_pkg::OPC_BRANCH:
			begin
				p.msg.is_branch = 1'b1;
				p.msg.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0}; // b-type
			end
			fetch_inst_pkg::OPC_STORE:
				p.msg.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]}; // s-type
			fetch_inst_pkg::OPC_LUI, fetch_inst_pkg::OPC_AUIPC:
				p.msg.imm = {inst[31:12], 12'h000}; // u-type
			fetch_inst_pkg::OPC_LOAD, fetch_inst_pkg::OPC_IMM,
			fetch_inst_pkg::OPC_FENCE, fetch_inst_pkg::OPC_SYSTEM:
				p.msg.imm = {{20{inst[31]}}, inst[31:20]}; // i-type
			fetch_inst_pkg::OPC_REG:
				p.msg.imm = '0; // r-type, no immediate
			default:
				known = 1'b0;
		endcase
	end

	assign p.is_jalr = p.msg.is_jalr;
	// compressed encodings count as illegal here
	assign p.illegal = (inst[1:0] != 2'b11) | ~known;

endmodule

`default_nettype wire

// File: next_pc_gen.sv
`default_nettype none

`include "fetch_defines.svh"

module next_pc_gen (
	predec_if.pcgen                   p,
	input  wire                       to_rst_i,
	input  wire                       to_flush_i,
	input  wire fetch_bus_pkg::addr_t flush_addr_i,
	input  wire fetch_bus_pkg::addr_t jalr_base_i
);

	fetch_bus_pkg::addr_t jalr_sum; // base + imm before clearing bit 0
	logic                 take;     // static prediction says jump

	assign jalr_sum = jalr_base_i + p.msg.imm;
	// jal always, conditional branch only when backward
	assign take = p.msg.is_jal | (p.msg.is_branch & p.msg.imm[31]);

	always_comb
	begin
		p.to_jump = 1'b0;
		if (to_rst_i)
			p.new_pc = `FETCH_RST_PC;
		else if (to_flush_i)
			p.new_pc = flush_addr_i;
		else if (p.msg.is_jalr)
			p.new_pc = {jalr_sum[`FETCH_ADDR_W-1:1], 1'b0};
		else if (take)
		begin
			p.new_pc = p.now_pc + p.msg.imm;
			p.to_jump = 1'b1;
		end
		else
			p.new_pc = p.now_pc + 32'd4; // fall through
	end

endmodule

`default_nettype wire

// File: imem_access_ctrler.sv
`default_nettype none

`include "fetch_defines.svh"

module imem_access_ctrler (
	input  wire                           clk,
	input  wire                           resetn,
	input  wire                           rst_req_i,
	input  wire                           flush_req_i,
	input  wire fetch_bus_pkg::addr_t     flush_addr_i,
	output logic                          rst_ack_o,
	output logic                          flush_ack_o,
	output logic                          to_rst_o,
	output logic                          to_flush_o,
	output fetch_bus_pkg::addr_t          flush_addr_hold_o,
	input  wire                           jalr_base_vld_i,
	input  wire fetch_bus_pkg::addr_t     jalr_base_i,
	output fetch_bus_pkg::addr_t          jalr_base_o,
	output fetch_bus_pkg::addr_t          req_addr_o,
	output logic                          req_valid_o,
	input  wire                           req_ready_i,
	input  wire fetch_bus_pkg::inst_t     resp_rdata_i,
	input  wire fetch_bus_pkg::imem_err_e resp_err_i,
	input  wire                           resp_valid_i,
	input  wire                           res_taken_i,
	predec_if.ctrl                        p,
	if_res_wr_if.wr                       w
);

	localparam fetch_bus_pkg::outstanding_t MAX_OUT = `IMEM_MAX_OUTSTANDING;
	localparam logic [1:0] LAST = `IMEM_MAX_OUTSTANDING - 1; // ring wrap point

	logic                         rst_pend;   // reset waiting for the bus
	logic                         flush_pend; // flush waiting for the bus
	logic                         norm_pend;  // fetched word still owes its successor
	fetch_bus_pkg::inst_t         inst_lat;
	fetch_bus_pkg::addr_t         flush_lat;
	fetch_bus_pkg::addr_t         now_pc_r;
	fetch_bus_pkg::outstanding_t  out_cnt;  // issued, not yet taken or dropped
	fetch_bus_pkg::outstanding_t  out_base; // out_cnt minus what a clear throws away
	fetch_bus_pkg::outstanding_t  buf_cnt;  // words sitting in the result buffer
	fetch_bus_pkg::addr_t         pc_ring [`IMEM_MAX_OUTSTANDING];
	logic [`IMEM_MAX_OUTSTANDING-1:0] supp_ring; // 1 = response belongs to an old stream
	logic [1:0]                   wptr;
	logic [1:0]                   rptr;
	logic                         restart;
	logic                         bus_free; // below limit and bus ready
	logic                         issue;
	logic                         resp_drop;
	logic                         resp_got;
	logic                         now_vld;
	logic                         jalr_ok;
	logic                         jb_flag; // jalr base held in jb_lat
	fetch_bus_pkg::addr_t         jb_lat;

	assign to_rst_o = rst_req_i | rst_pend;
	assign to_flush_o = flush_req_i | flush_pend;
	assign restart = to_rst_o | to_flush_o;
	assign flush_addr_hold_o = flush_req_i ? flush_addr_i : flush_lat;

	assign bus_free = (out_cnt != MAX_OUT) & req_ready_i;
	assign jalr_ok = jalr_base_vld_i | jb_flag;
	assign jalr_base_o = jb_flag ? jb_lat : jalr_base_i;

	// anything answering during a restart is from before it
	assign resp_drop = resp_valid_i & (restart | supp_ring[rptr]);
	assign resp_got = resp_valid_i & ~resp_drop;
	assign now_vld = resp_got | norm_pend;

	assign req_addr_o = p.new_pc;
	assign req_valid_o = (out_cnt != MAX_OUT) & (restart | (now_vld & (~p.is_jalr | jalr_ok)));
	assign issue = req_valid_o & req_ready_i;
	assign rst_ack_o = to_rst_o & issue;
	assign flush_ack_o = to_flush_o & issue;

	assign p.now_inst = norm_pend ? inst_lat : resp_rdata_i;
	assign p.now_pc = now_pc_r;

	assign w.clr = rst_req_i | flush_req_i;
	assign w.wen = resp_got & ~w.full; // never overwrite a full buffer
	assign w.pc = pc_ring[rptr]; // pc of the request being answered
	assign w.inst = resp_rdata_i;
	assign w.predec = p.msg;
	assign w.msg = {p.to_jump, p.illegal, resp_err_i};

	assign out_base = w.clr ? out_cnt - buf_cnt : out_cnt;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			rst_pend <= 1'b0;
			flush_pend <= 1'b0;
			norm_pend <= 1'b0;
		end
		else
		begin
			rst_pend <= (rst_pend | rst_req_i) & ~bus_free;
			// a reset request drops a pending flush
			flush_pend <= (flush_pend ? ~rst_req_i : flush_req_i) & ~bus_free;
			norm_pend <= ~w.clr & (norm_pend | resp_got) & ~issue;
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			out_cnt <= '0;
			buf_cnt <= '0;
		end
		else
		begin
			out_cnt <= out_base + {1'b0, issue} - {1'b0, res_taken_i} - {1'b0, resp_drop};
			if (w.clr)
				buf_cnt <= '0;
			else
				buf_cnt <= buf_cnt + {1'b0, w.wen} - {1'b0, res_taken_i};
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			wptr <= '0;
			rptr <= '0;
			supp_ring <= '0;
			jb_flag <= 1'b0;
		end
		else
		begin
			if (issue)
			begin
				wptr <= (wptr == LAST) ? 2'd0 : wptr + 2'd1;
				// new entry is live, on restart every other one is stale
				for (int i = 0; i < `IMEM_MAX_OUTSTANDING; i++)
				begin
					if (i == int'(wptr))
						supp_ring[i] <= 1'b0;
					else if (restart)
						supp_ring[i] <= 1'b1;
				end
			end
			if (resp_valid_i)
				rptr <= (rptr == LAST) ? 2'd0 : rptr + 2'd1; // responses come in order
			if (jalr_base_vld_i | issue)
				jb_flag <= jalr_base_vld_i & ~issue; // held until next transfer
		end
	end

	always_ff @(posedge clk)
	begin
		if (resp_valid_i)
			inst_lat <= resp_rdata_i;
		if (flush_req_i)
			flush_lat <= flush_addr_i;
		if (jalr_base_vld_i)
			jb_lat <= jalr_base_i;
		if (issue)
		begin
			now_pc_r <= p.new_pc;
			pc_ring[wptr] <= p.new_pc;
		end
	end

endmodule

`default_nettype wire

// File: if_res_buf.sv
`default_nettype none

`include "fetch_defines.svh"

module if_res_buf (
	input  wire                         clk,
	input  wire                         resetn,
	if_res_wr_if.fifo                   w,
	input  wire                         res_ready_i,
	output logic                        res_valid_o,
	output fetch_bus_pkg::addr_t        res_pc_o,
	output fetch_bus_pkg::inst_t        res_inst_o,
	output fetch_inst_pkg::predec_msg_t res_predec_o,
	output fetch_inst_pkg::if_res_msg_t res_msg_o,
	output logic                        res_taken_o
);

	localparam logic [1:0] LAST = `IF_RES_DEPTH - 1;

	logic [`IF_RES_DEPTH:0]      occ; // one-hot fill level, bit 0 = empty
	logic [1:0]                  wptr;
	logic [1:0]                  rptr;
	fetch_bus_pkg::addr_t        pc_q     [`IF_RES_DEPTH];
	fetch_bus_pkg::inst_t        inst_q   [`IF_RES_DEPTH];
	fetch_inst_pkg::predec_msg_t predec_q [`IF_RES_DEPTH];
	fetch_inst_pkg::if_res_msg_t msg_q    [`IF_RES_DEPTH];

	assign res_valid_o = ~w.clr & ~occ[0]; // nothing leaves in a clear cycle
	assign res_taken_o = res_valid_o & res_ready_i;
	assign w.full = occ[`IF_RES_DEPTH];

	assign res_pc_o = pc_q[rptr];
	assign res_inst_o = inst_q[rptr];
	assign res_predec_o = predec_q[rptr];
	assign res_msg_o = msg_q[rptr];

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			occ <= 1;
			wptr <= '0;
			rptr <= '0;
		end
		else if (w.clr)
		begin
			occ <= 1;
			wptr <= '0;
			rptr <= '0;
		end
		else
		begin
			if (w.wen ^ res_taken_o)
				occ <= w.wen ? {occ[`IF_RES_DEPTH-1:0], 1'b0} : {1'b0, occ[`IF_RES_DEPTH:1]};
			if (w.wen)
				wptr <= (wptr == LAST) ? 2'd0 : wptr + 2'd1;
			if (res_taken_o)
				rptr <= (rptr == LAST) ? 2'd0 : rptr + 2'd1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (w.wen)
		begin
			pc_q[wptr] <= w.pc;
			inst_q[wptr] <= w.inst;
			predec_q[wptr] <= w.predec;
			msg_q[wptr] <= w.msg;
		end
	end

endmodule

`default_nettype wire

// File: fetch_top.sv
`default_nettype none

module fetch_top (
	input  wire          clk,
	input  wire          resetn,
	output logic [31:0]  imem_req_addr_o,
	output logic         imem_req_valid_o,
	input  wire          imem_req_ready_i,
	input  wire  [31:0]  imem_resp_rdata_i,
	input  wire  [1:0]   imem_resp_err_i,
	input  wire          imem_resp_valid_i,
	input  wire          rst_req_i,
	input  wire          flush_req_i,
	input  wire  [31:0]  flush_addr_i,
	output logic         rst_ack_o,
	output logic         flush_ack_o,
	input  wire          jalr_base_vld_i,
	input  wire  [31:0]  jalr_base_i,
	output logic [127:0] if_res_data_o, // {pc, pre-decode, instruction}
	output logic [3:0]   if_res_msg_o,  // {jump, illegal, err}
	output logic         if_res_valid_o,
	input  wire          if_res_ready_i
);

	logic                        to_rst;
	logic                        to_flush;
	fetch_bus_pkg::addr_t        flush_addr_hold;
	fetch_bus_pkg::addr_t        jalr_base;
	fetch_bus_pkg::imem_err_e    resp_err;
	logic                        res_taken;
	fetch_bus_pkg::addr_t        res_pc;
	fetch_bus_pkg::inst_t        res_inst;
	fetch_inst_pkg::predec_msg_t res_predec;
	fetch_inst_pkg::if_res_msg_t res_msg;

	predec_if    pd ();
	if_res_wr_if rw ();

	assign resp_err = fetch_bus_pkg::imem_err_e'(imem_resp_err_i);
	assign if_res_data_o = {res_pc, res_predec, res_inst};
	assign if_res_msg_o = res_msg;

	inst_predecoder u_dec (.p(pd));

	next_pc_gen u_pcgen (
		.p(pd), .to_rst_i(to_rst), .to_flush_i(to_flush),
		.flush_addr_i(flush_addr_hold), .jalr_base_i(jalr_base)
	);

	imem_access_ctrler u_ctrl (
		.clk(clk), .resetn(resetn),
		.rst_req_i(rst_req_i), .flush_req_i(flush_req_i), .flush_addr_i(flush_addr_i),
		.rst_ack_o(rst_ack_o), .flush_ack_o(flush_ack_o),
		.to_rst_o(to_rst), .to_flush_o(to_flush), .flush_addr_hold_o(flush_addr_hold),
		.jalr_base_vld_i(jalr_base_vld_i), .jalr_base_i(jalr_base_i), .jalr_base_o(jalr_base),
		.req_addr_o(imem_req_addr_o), .req_valid_o(imem_req_valid_o),
		.req_ready_i(imem_req_ready_i),
		.resp_rdata_i(imem_resp_rdata_i), .resp_err_i(resp_err),
		.resp_valid_i(imem_resp_valid_i),
		.res_taken_i(res_taken), .p(pd), .w(rw)
	);

	if_res_buf u_buf (
		.clk(clk), .resetn(resetn), .w(rw), .res_ready_i(if_res_ready_i),
		.res_valid_o(if_res_valid_o), .res_pc_o(res_pc), .res_inst_o(res_inst),
		.res_predec_o(res_predec), .res_msg_o(res_msg), .res_taken_o(res_taken)
	);

endmodule

`default_nettype wire

// File: fetch_tb.sv
`default_nettype none

`include "fetch_defines.svh"

module fetch_tb;

	localparam int MAX_REC = 64;
	localparam int CYC_PER_RES = 40; // timeout budget per expected result

	// one pattern line is {kind, a, b, c}, 4 + 32 + 32 + 4 bits
	logic [71:0]  recs [MAX_REC];

	logic         clk;
	logic         resetn;
	logic [31:0]  imem_req_addr;
	logic         imem_req_valid;
	logic         imem_req_ready;
	logic [31:0]  imem_resp_rdata;
	logic [1:0]   imem_resp_err;
	logic         imem_resp_valid;
	logic         rst_req;
	logic         flush_req;
	logic [31:0]  flush_addr;
	logic         rst_ack;
	logic         flush_ack;
	logic         jalr_base_vld;
	logic [31:0]  jalr_base;
	logic [127:0] if_res_data;
	logic [3:0]   if_res_msg;
	logic         if_res_valid;
	logic         if_res_ready;

	logic [31:0]  mem_word [64]; // word image for 0x00..0xfc
	logic [1:0]   mem_err  [64];
	logic         mem_set  [64];
	logic [31:0]  exp_pc   [$];
	logic [31:0]  exp_inst [$];
	logic [3:0]   exp_msg  [$];
	logic [31:0]  q_addr   [$]; // accepted requests waiting for their response
	int           q_due    [$];
	int           flush_after; // flush once this many results are taken
	logic [31:0]  flush_pc;
	logic [31:0]  jalr_val;
	int           cyc;
	int           last_due;
	int           res_idx;
	int           n_exp;
	int           limit;
	int           errors;
	int           checks;
	int           acc_win;   // requests accepted since the last restart
	int           taken_win; // results taken since the last restart
	int           rst_acks;  // rst_ack pulses seen
	int           flush_acks;
	logic         done;
	logic         timed_out;

	fetch_top u_dut (
		.clk(clk), .resetn(resetn),
		.imem_req_addr_o(imem_req_addr), .imem_req_valid_o(imem_req_valid),
		.imem_req_ready_i(imem_req_ready),
		.imem_resp_rdata_i(imem_resp_rdata), .imem_resp_err_i(imem_resp_err),
		.imem_resp_valid_i(imem_resp_valid),
		.rst_req_i(rst_req), .flush_req_i(flush_req), .flush_addr_i(flush_addr),
		.rst_ack_o(rst_ack), .flush_ack_o(flush_ack),
		.jalr_base_vld_i(jalr_base_vld), .jalr_base_i(jalr_base),
		.if_res_data_o(if_res_data), .if_res_msg_o(if_res_msg),
		.if_res_valid_o(if_res_valid), .if_res_ready_i(if_res_ready)
	);

	always #2 clk = ~clk;

	// words outside the image are addi x1, x0, imm with imm built from the address
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		logic [11:0] imm;
		if (addr[31:8] == '0 && mem_set[addr[7:2]])
			return mem_word[addr[7:2]];
		imm = addr[13:2] ^ addr[31:20] ^ {4'b0, addr[19:14], addr[1:0]};
		return {imm, 5'd0, 3'b000, 5'd1, 7'b0010011};
	endfunction

	function automatic logic [1:0] err_at(input logic [31:0] addr);
		if (addr[31:8] == '0 && mem_set[addr[7:2]])
			return mem_err[addr[7:2]];
		return 2'b00;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	// memory model, result sink and event drivers
	always @(posedge clk)
	begin
		int          due;
		int          err_before;
		logic [31:0] resp_addr;
		logic [31:0] pc;
		logic [31:0] inst;
		logic [63:0] pd;
		logic [31:0] ei;
		cyc = cyc + 1;
		if (rst_ack || flush_ack)
			check_value("ack with transfer", 32'd1, {31'b0, imem_req_valid & imem_req_ready});
		if (rst_ack)
		begin
			rst_acks++;
			check_value("imem_req_addr", `FETCH_RST_PC, imem_req_addr);
		end
		if (flush_ack)
		begin
			flush_acks++;
			check_value("imem_req_addr", flush_pc, imem_req_addr);
		end
		if (imem_req_valid && imem_req_ready)
		begin
			due = cyc + 1 + int'($urandom % 3); // 1 to 3 cycles
			if (due <= last_due)
				due = last_due + 1; // keep responses in order
			last_due = due;
			q_addr.push_back(imem_req_addr);
			q_due.push_back(due);
			if (rst_ack || flush_ack)
			begin
				acc_win = 1;
				taken_win = 0;
			end
			else
				acc_win++;
		end
		if (q_due.size() > 0 && q_due[0] == cyc)
		begin
			resp_addr = q_addr.pop_front();
			void'(q_due.pop_front());
			imem_resp_valid <= 1'b1;
			imem_resp_rdata <= word_at(resp_addr);
			imem_resp_err <= err_at(resp_addr);
		end
		else
			imem_resp_valid <= 1'b0;
		imem_req_ready <= ($urandom % 4) != 0; // low 1 in 4
		if_res_ready <= ($urandom % 2) == 0;
		flush_req <= 1'b0;
		jalr_base_vld <= 1'b0;
		if (if_res_valid && if_res_ready && !done)
		begin
			err_before = errors;
			pc = if_res_data[127:96];
			pd = if_res_data[95:32];
			inst = if_res_data[31:0];
			ei = exp_inst[res_idx];
			check_value("if_res_pc", exp_pc[res_idx], pc);
			check_value("if_res_inst", exp_inst[res_idx], inst);
			check_value("if_res_msg", {28'b0, exp_msg[res_idx]}, {28'b0, if_res_msg});
			check_value("mem word at pc", word_at(pc), inst);
			// flags by major opcode, reserved bits zero
			check_value("if_res_predec flags",
				{29'b0, ei[6:0] == 7'b1100011, ei[6:0] == 7'b1101111, ei[6:0] == 7'b1100111},
				{10'b0, pd[63:42]});
			check_value("if_res_predec rs1 rd", {22'b0, ei[19:15], ei[11:7]}, {22'b0, pd[41:32]});
			// immediate seen through the pc of the next result
			if (res_idx + 1 < n_exp && res_idx + 1 != flush_after)
			begin
				if (exp_msg[res_idx][3])
					check_value("if_res_predec imm",
						exp_pc[res_idx + 1] - exp_pc[res_idx], pd[31:0]);
				else if (ei[6:0] == 7'b1100111)
					check_value("jalr_base + imm", exp_pc[res_idx + 1],
						(jalr_val + pd[31:0]) & ~32'd1);
			end
			$display("result %0d pc %h: %s", res_idx, pc,
				(errors == err_before) ? "ok" : "mismatch");
			taken_win++;
			// jalr waits for its base from outside
			if (exp_inst[res_idx][6:0] == 7'b1100111)
			begin
				jalr_base_vld <= 1'b1;
				jalr_base <= jalr_val;
			end
			res_idx++;
			if (res_idx == flush_after)
			begin
				flush_req <= 1'b1;
				flush_addr <= flush_pc;
				if_res_ready <= 1'b0; // nothing taken in the flush cycle
			end
			if (res_idx == n_exp)
				done = 1'b1;
		end
		if (acc_win - taken_win > `IMEM_MAX_OUTSTANDING)
		begin
			errors++;
			$display("more than %0d requests outstanding at time %0t",
				`IMEM_MAX_OUTSTANDING, $time);
		end
		if (!done && !timed_out && cyc > limit)
		begin
			timed_out = 1'b1;
			$display("timeout after %0d cycles waiting for result %0d", cyc, res_idx);
		end
	end

	initial
	begin
		logic [3:0]  kind;
		logic [31:0] ra;
		logic [31:0] rb;
		logic [3:0]  rc;
		void'($urandom(32'h3f3f));
		clk = 1'b0;
		resetn = 1'b0;
		rst_req = 1'b0;
		flush_req = 1'b0;
		flush_addr = '0;
		imem_req_ready = 1'b0;
		imem_resp_valid = 1'b0;
		imem_resp_rdata = '0;
		imem_resp_err = '0;
		jalr_base_vld = 1'b0;
		jalr_base = '0;
		if_res_ready = 1'b0;
		cyc = 0;
		last_due = 0;
		res_idx = 0;
		errors = 0;
		checks = 0;
		acc_win = 0;
		taken_win = 0;
		rst_acks = 0;
		flush_acks = 0;
		done = 1'b0;
		timed_out = 1'b0;
		flush_after = -1;
		flush_pc = '0;
		jalr_val = '0;
		for (int i = 0; i < 64; i++)
		begin
			mem_word[i] = '0;
			mem_err[i] = '0;
			mem_set[i] = 1'b0;
		end
		for (int i = 0; i < MAX_REC; i++)
			recs[i] = '0;
		$readmemh("fetch_patterns.txt", recs);
		for (int i = 0; i < MAX_REC; i++)
		begin
			{kind, ra, rb, rc} = recs[i];
			case (kind)
				4'h1:
				begin
					mem_word[ra[7:2]] = rb;
					mem_err[ra[7:2]] = rc[1:0];
					mem_set[ra[7:2]] = 1'b1;
				end
				4'h2:
				begin
					flush_after = int'(ra);
					flush_pc = rb;
				end
				4'h3: jalr_val = rb;
				4'h4:
				begin
					exp_pc.push_back(ra);
					exp_inst.push_back(rb);
					exp_msg.push_back(rc);
				end
				default: ; // unused slot
			endcase
		end
		n_exp = exp_pc.size();
		limit = CYC_PER_RES * n_exp;
		repeat (3) @(posedge clk);
		resetn <= 1'b1;
		@(posedge clk);
		rst_req <= 1'b1;
		@(posedge clk);
		rst_req <= 1'b0;
		wait (done || timed_out);
		// one reset and at most one flush were requested
		check_value("rst_ack count", 32'd1, rst_acks);
		check_value("flush_ack count", (flush_after >= 0) ? 32'd1 : 32'd0, flush_acks);
		$display("checks %0d, errors %0d, results %0d of %0d", checks, errors, res_idx, n_exp);
		if (errors == 0 && !timed_out)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: fetch_patterns.txt
// kind_a_b_c; kind 1 memory word: a address, b word, c response error
// kind 2 flush after a results to address b; kind 3 jalr base b; kind 4 expected pc, word, msg
1_00000000_00100093_0
1_00000004_00200113_0
1_00000008_0100006f_0
1_00000010_00428067_0
1_00000018_00300193_2
1_0000001c_00000000_0
1_00000020_00000463_0
1_00000024_fe0006e3_0
1_00000044_00400213_3
1_00000048_00500293_0
1_00000080_00600313_0
1_00000084_00700393_0
1_00000088_ff9ff06f_0
2_0000000a_00000080_0
3_00000000_00000041_0
4_00000000_00100093_0
4_00000004_00200113_0
4_00000008_0100006f_8
4_00000018_00300193_2
4_0000001c_00000000_4
4_00000020_00000463_0
4_00000024_fe0006e3_8
4_00000010_00428067_0
4_00000044_00400213_3
4_00000048_00500293_0
4_00000080_00600313_0
4_00000084_00700393_0
4_00000088_ff9ff06f_8
4_00000080_00600313_0
4_00000084_00700393_0

// File: sources.f
+incdir+.
fetch_bus_pkg.sv
fetch_inst_pkg.sv
fetch_ifs.sv
inst_predecoder.sv
next_pc_gen.sv
imem_access_ctrler.sv
if_res_buf.sv
fetch_top.sv
fetch_tb.sv

// File: Makefile
SIM := obj_dir/fetch_sim

.PHONY: compile run clean

compile:
	verilator --binary -Wno-fatal --top-module fetch_tb -f sources.f -o fetch_sim

run: compile
	./$(SIM) | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
